// File: verilog/gfx_pkg.sv
// Shared widths and types for the graphics host
// Tile addressing assumes a square frame buffer, so FB_ADDR_W must be even

package gfx_pkg;

    // Address widths set the memory depths
    localparam int FB_ADDR_W  = 10;
    localparam int PAL_ADDR_W = 8;
    localparam int PIXEL_W    = 32;
    localparam int COLOUR_W   = 24;
    localparam int COORD_W    = 16;

    localparam int TILE_W    = FB_ADDR_W / 2;  // 32x32 tile
    localparam int FB_WORDS  = 1 << FB_ADDR_W;
    localparam int PAL_WORDS = 1 << PAL_ADDR_W;

    typedef logic [FB_ADDR_W-1:0]  fb_addr_t;
    typedef logic [PAL_ADDR_W-1:0] pal_addr_t;
    typedef logic [PIXEL_W-1:0]    pixel_t;
    typedef logic [COLOUR_W-1:0]   colour_t;
    typedef logic [COORD_W-1:0]    coord_t;

    // Fold a coordinate pair into the tile, i.e. (y mod 32) * 32 + (x mod 32)
    function automatic fb_addr_t tile_addr(input coord_t x, input coord_t y);
        return {y[TILE_W-1:0], x[TILE_W-1:0]};
    endfunction

endpackage

// File: verilog/sync_ram.sv
// Register-array RAM with one write port and a registered read port
// Contents are undefined until written; a same-cycle read returns the old word

`timescale 1ns/1ns

module sync_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 1024,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  word_t             wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output word_t             rdata_o
);

    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Read port, one cycle latency
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

    // Writes must carry a known, in-range address
    a_waddr_in_range: assert property (
        @(posedge clk)
        we_i |-> !$isunknown(waddr_i) && (int'(waddr_i) < DEPTH)
    );

endmodule

// File: verilog/host_port.sv
// Host write port for frame buffer and palette, one cycle from strobe to RAM write
// Writes seen while a scan is running are dropped without notice beyond busy_i

`timescale 1ns/1ns

module host_port (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::pixel_t    pixel_data_i,
    input  gfx_pkg::coord_t    pixel_x_i,
    input  gfx_pkg::coord_t    pixel_y_i,
    input  logic               pixel_write_i,
    input  gfx_pkg::colour_t   pal_data_i,
    input  gfx_pkg::pal_addr_t pal_index_i,
    input  logic               pal_write_i,
    input  logic               busy_i,
    output logic               fb_we_o,
    output gfx_pkg::fb_addr_t  fb_waddr_o,
    output gfx_pkg::pixel_t    fb_wdata_o,
    output logic               pal_we_o,
    output gfx_pkg::pal_addr_t pal_waddr_o,
    output gfx_pkg::colour_t   pal_wdata_o
);

    logic pix_accept;
    logic pal_accept;

    // Only place where busy decides the fate of a write
    assign pix_accept = pixel_write_i && !busy_i;
    assign pal_accept = pal_write_i && !busy_i;

    // Write enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fb_we_o  <= 1'b0;
            pal_we_o <= 1'b0;
        end else begin
            fb_we_o  <= pix_accept;
            pal_we_o <= pal_accept;
        end
    end

    // Frame buffer address and data
    always_ff @(posedge clk) begin
        if (pix_accept) begin
            fb_waddr_o <= gfx_pkg::tile_addr(pixel_x_i, pixel_y_i);  // x, y wrap in tile
            fb_wdata_o <= pixel_data_i;
        end
    end

    // Palette index and colour
    always_ff @(posedge clk) begin
        if (pal_accept) begin
            pal_waddr_o <= pal_index_i;
            pal_wdata_o <= pal_data_i;
        end
    end

    // A write accepted in the cycle of frame_start may land in the first busy cycle,
    // but none may land once the scan has been running for a cycle
    a_no_write_in_scan: assert property (
        @(posedge clk) disable iff (rst)
        busy_i && $past(busy_i) |-> !fb_we_o && !pal_we_o
    );

endmodule

// File: verilog/scan_controller.sv
// Raster scan engine, one address per cycle, display data 2 cycles after its address
// No blanking or porches; hsync, vsync and frame_ready are single-cycle pulses

`timescale 1ns/1ns

module scan_controller #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame_start_i,
    input  gfx_pkg::pixel_t    fb_rdata_i,
    input  gfx_pkg::colour_t   pal_rdata_i,
    output gfx_pkg::fb_addr_t  fb_raddr_o,
    output gfx_pkg::pal_addr_t pal_raddr_o,
    output gfx_pkg::pixel_t    display_data_o,
    output logic               pixel_valid_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               frame_ready_o,
    output logic               busy_o
);

    typedef enum logic {
        IDLE,
        SCAN
    } state_t;

    state_t          state;
    logic            issuing;    // Addresses still to be issued
    gfx_pkg::coord_t x_cnt;
    gfx_pkg::coord_t y_cnt;
    logic            last_x;
    logic            last_y;

    // Stage 1 lines up with fb_rdata_i, stage 2 with pal_rdata_i
    logic valid_s1;
    logic valid_s2;
    logic eol_s1;
    logic eol_s2;
    logic eof_s1;
    logic eof_s2;

    assign last_x = (x_cnt == gfx_pkg::coord_t'(FRAME_WIDTH - 1));
    assign last_y = (y_cnt == gfx_pkg::coord_t'(FRAME_HEIGHT - 1));

    // State and raster counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            issuing <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_start_i) begin
                        state   <= SCAN;
                        issuing <= 1'b1;
                        x_cnt   <= '0;
                        y_cnt   <= '0;
                    end
                end
                SCAN: begin
                    // frame_start_i is ignored here
                    if (issuing) begin
                        if (last_x) begin
                            x_cnt <= '0;
                            if (last_y) begin
                                issuing <= 1'b0;  // last address out, drain pipeline
                            end else begin
                                y_cnt <= y_cnt + 1'b1;
                            end
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                    if (vsync_o) begin
                        state <= IDLE;  // busy drops the cycle after vsync
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Strobe pipeline matched to the two RAM reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_s1      <= 1'b0;
            valid_s2      <= 1'b0;
            eol_s1        <= 1'b0;
            eol_s2        <= 1'b0;
            eof_s1        <= 1'b0;
            eof_s2        <= 1'b0;
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            frame_ready_o <= 1'b0;
        end else begin
            valid_s1      <= issuing;
            eol_s1        <= issuing && last_x;
            eof_s1        <= issuing && last_x && last_y;
            valid_s2      <= valid_s1;
            eol_s2        <= eol_s1;
            eof_s2        <= eof_s1;
            hsync_o       <= eol_s2;  // Cycle after the last valid of a line
            vsync_o       <= eof_s2;
            frame_ready_o <= eof_s2;
        end
    end

    assign fb_raddr_o  = gfx_pkg::tile_addr(x_cnt, y_cnt);
    assign pal_raddr_o = fb_rdata_i[gfx_pkg::PAL_ADDR_W-1:0];  // Low byte is the index

    // Colour zero-extended, held at zero between valid pixels
    assign display_data_o = valid_s2 ? {8'h00, pal_rdata_i} : '0;
    assign pixel_valid_o  = valid_s2;
    assign busy_o         = (state == SCAN);

    a_hsync_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        hsync_o |=> !hsync_o
    );

    // End of frame comes with ready and the last hsync, then the engine goes idle
    a_vsync_frame_end: assert property (
        @(posedge clk) disable iff (rst)
        vsync_o |-> (frame_ready_o && hsync_o) ##1 !busy_o
    );

endmodule

// File: verilog/gfx_host.sv
// Graphics host top level, frame buffer and palette in two RAM instances
// Memories are not cleared by reset; every location read must be written first

`timescale 1ns/1ns

module gfx_host #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::pixel_t    pixel_data_i,
    input  gfx_pkg::coord_t    pixel_x_i,
    input  gfx_pkg::coord_t    pixel_y_i,
    input  logic               pixel_write_i,
    input  gfx_pkg::colour_t   pal_data_i,
    input  gfx_pkg::pal_addr_t pal_index_i,
    input  logic               pal_write_i,
    input  logic               frame_start_i,
    output gfx_pkg::pixel_t    display_data_o,
    output logic               pixel_valid_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               frame_ready_o,
    output logic               busy_o
);

    // Write side
    logic               fb_we;
    gfx_pkg::fb_addr_t  fb_waddr;
    gfx_pkg::pixel_t    fb_wdata;
    logic               pal_we;
    gfx_pkg::pal_addr_t pal_waddr;
    gfx_pkg::colour_t   pal_wdata;

    // Read side
    gfx_pkg::fb_addr_t  fb_raddr;
    gfx_pkg::pixel_t    fb_rdata;
    gfx_pkg::pal_addr_t pal_raddr;
    gfx_pkg::colour_t   pal_rdata;

    logic busy;

    host_port host_port0 (
        .clk           (clk),
        .rst           (rst),
        .pixel_data_i  (pixel_data_i),
        .pixel_x_i     (pixel_x_i),
        .pixel_y_i     (pixel_y_i),
        .pixel_write_i (pixel_write_i),
        .pal_data_i    (pal_data_i),
        .pal_index_i   (pal_index_i),
        .pal_write_i   (pal_write_i),
        .busy_i        (busy),
        .fb_we_o       (fb_we),
        .fb_waddr_o    (fb_waddr),
        .fb_wdata_o    (fb_wdata),
        .pal_we_o      (pal_we),
        .pal_waddr_o   (pal_waddr),
        .pal_wdata_o   (pal_wdata)
    );

    scan_controller #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) scan0 (
        .clk            (clk),
        .rst            (rst),
        .frame_start_i  (frame_start_i),
        .fb_rdata_i     (fb_rdata),
        .pal_rdata_i    (pal_rdata),
        .fb_raddr_o     (fb_raddr),
        .pal_raddr_o    (pal_raddr),
        .display_data_o (display_data_o),
        .pixel_valid_o  (pixel_valid_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .frame_ready_o  (frame_ready_o),
        .busy_o         (busy)
    );

    assign busy_o = busy;

    // 1024 x 32 frame buffer
    sync_ram #(
        .word_t (gfx_pkg::pixel_t),
        .DEPTH  (gfx_pkg::FB_WORDS)
    ) fb_ram (
        .clk     (clk),
        .we_i    (fb_we),
        .waddr_i (fb_waddr),
        .wdata_i (fb_wdata),
        .raddr_i (fb_raddr),
        .rdata_o (fb_rdata)
    );

    // 256 x 24 palette
    sync_ram #(
        .word_t (gfx_pkg::colour_t),
        .DEPTH  (gfx_pkg::PAL_WORDS)
    ) pal_ram (
        .clk     (clk),
        .we_i    (pal_we),
        .waddr_i (pal_waddr),
        .wdata_i (pal_wdata),
        .raddr_i (pal_raddr),
        .rdata_o (pal_rdata)
    );

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset, reset held high for RESET_CYCLES rising edges

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;  // Released on an edge like any driven input
    end

endmodule

// File: tests/gfx_checker.sv
// Scoreboard for gfx_host that samples every port on the falling edge
// Shadow memories track only writes made while busy is low; scan timing is fixed

`timescale 1ns/1ns

module gfx_checker #(
    parameter int FRAME_WIDTH  = 8,
    parameter int FRAME_HEIGHT = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::pixel_t    pixel_data_i,
    input  gfx_pkg::coord_t    pixel_x_i,
    input  gfx_pkg::coord_t    pixel_y_i,
    input  logic               pixel_write_i,
    input  gfx_pkg::colour_t   pal_data_i,
    input  gfx_pkg::pal_addr_t pal_index_i,
    input  logic               pal_write_i,
    input  logic               frame_start_i,
    input  gfx_pkg::pixel_t    display_data_i,
    input  logic               pixel_valid_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    input  logic               frame_ready_i,
    input  logic               busy_i,
    output int                 errors_o
);

    localparam int PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    gfx_pkg::pixel_t  fb_shadow [gfx_pkg::FB_WORDS];
    gfx_pkg::colour_t pal_shadow [gfx_pkg::PAL_WORDS];

    logic            in_frame;
    int              t;  // Falling edges since the accepted frame_start
    int              p;
    logic            exp_valid;
    logic            exp_hsync;
    logic            exp_end;
    logic            exp_busy;
    gfx_pkg::pixel_t exp_data;

    initial errors_o = 0;

    function automatic string where_str();
        if (in_frame) begin
            return $sformatf("at scan cycle %0d", t);
        end
        return "outside a scan";
    endfunction

    // Raster pixel p through the 32x32 tile and the palette
    function automatic gfx_pkg::pixel_t expected_pixel(input int pix);
        int x;
        int y;
        int addr;
        x    = pix % FRAME_WIDTH;
        y    = pix / FRAME_WIDTH;
        addr = (y % 32) * 32 + (x % 32);
        return {8'h00, pal_shadow[fb_shadow[addr][7:0]]};
    endfunction

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors_o++;
            if (actual === 1'b1) begin
                $display("%s is high %s but should be low", name, where_str());
            end else begin
                $display("%s is not high %s although it should be", name, where_str());
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            in_frame = 1'b0;
            t        = 0;
        end else begin
            // Writes only count while idle
            if (pixel_write_i && !busy_i) begin
                fb_shadow[(pixel_y_i % 32) * 32 + (pixel_x_i % 32)] = pixel_data_i;
            end
            if (pal_write_i && !busy_i) begin
                pal_shadow[pal_index_i] = pal_data_i;
            end
            if (frame_start_i && !busy_i && !in_frame) begin
                in_frame = 1'b1;
                t        = 0;
            end else if (in_frame) begin
                t++;
            end

            exp_valid = in_frame && t >= 3 && t <= PIXELS + 2;
            exp_hsync = in_frame && t > 3 && t <= PIXELS + 3 && (t - 3) % FRAME_WIDTH == 0;
            exp_end   = in_frame && t == PIXELS + 3;  // Last line's hsync
            exp_busy  = in_frame && t >= 1 && t <= PIXELS + 3;

            check_strobe("pixel_valid_o", pixel_valid_i, exp_valid);
            check_strobe("hsync_o", hsync_i, exp_hsync);
            check_strobe("vsync_o", vsync_i, exp_end);
            check_strobe("frame_ready_o", frame_ready_i, exp_end);
            check_strobe("busy_o", busy_i, exp_busy);

            if (exp_valid && pixel_valid_i === 1'b1) begin
                p        = t - 3;
                exp_data = expected_pixel(p);
                if (display_data_i !== exp_data) begin
                    errors_o++;
                    $display("FAIL display_data_o at pixel (%0d,%0d): expected %h, got %h",
                             p % FRAME_WIDTH, p / FRAME_WIDTH, exp_data, display_data_i);
                end
            end

            // No pixel on the display side means zero data
            if (!exp_valid && display_data_i !== '0) begin
                errors_o++;
                $display("FAIL display_data_o %s with no valid pixel: expected %h, got %h",
                         where_str(), 32'h0, display_data_i);
            end

            if (in_frame && t == PIXELS + 4) begin
                in_frame = 1'b0;  // busy_o low checked above
            end
        end
    end

endmodule

// File: tests/gfx_host_tb.sv
// Testbench for gfx_host on an 8x4 raster with the stimulus table built at time zero
// Memories are not reset, so every palette entry and tile word that a scan reads is written

`timescale 1ns/1ns

module gfx_host_tb;

    localparam int FRAME_W      = 8;
    localparam int FRAME_H      = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_ROWS     = 400;

    localparam int OP_IDLE  = 0;
    localparam int OP_PIX   = 1;
    localparam int OP_PAL   = 2;
    localparam int OP_START = 3;
    localparam int OP_WAIT  = 4;  // Waits for frame_ready_o and one more cycle

    logic               clk;
    logic               rst;
    gfx_pkg::pixel_t    pixel_data;
    gfx_pkg::coord_t    pixel_x;
    gfx_pkg::coord_t    pixel_y;
    logic               pixel_write;
    gfx_pkg::colour_t   pal_data;
    gfx_pkg::pal_addr_t pal_index;
    logic               pal_write;
    logic               frame_start;
    gfx_pkg::pixel_t    display_data;
    logic               pixel_valid;
    logic               hsync;
    logic               vsync;
    logic               frame_ready;
    logic               busy;
    int                 chk_errors;

    // Stimulus table with one column per array
    int          row_test [MAX_ROWS];
    int          row_op   [MAX_ROWS];
    int          row_x    [MAX_ROWS];
    int          row_y    [MAX_ROWS];
    int          row_idx  [MAX_ROWS];
    logic [31:0] row_data [MAX_ROWS];
    bit          row_drop [MAX_ROWS];  // Strobe expected to be dropped

    int     n_rows = 0;
    integer seed   = 20362;
    int     cycles = 0;
    int     limit  = 0;
    int     tb_errors    = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    string  test_name [7];

    tb_clock #(.PERIOD(40), .RESET_CYCLES(RESET_CYCLES)) clock0 (.clk_o(clk), .rst_o(rst));

    gfx_host #(
        .FRAME_WIDTH  (FRAME_W),
        .FRAME_HEIGHT (FRAME_H)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .pixel_data_i   (pixel_data),
        .pixel_x_i      (pixel_x),
        .pixel_y_i      (pixel_y),
        .pixel_write_i  (pixel_write),
        .pal_data_i     (pal_data),
        .pal_index_i    (pal_index),
        .pal_write_i    (pal_write),
        .frame_start_i  (frame_start),
        .display_data_o (display_data),
        .pixel_valid_o  (pixel_valid),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .frame_ready_o  (frame_ready),
        .busy_o         (busy)
    );

    gfx_checker #(
        .FRAME_WIDTH  (FRAME_W),
        .FRAME_HEIGHT (FRAME_H)
    ) chk0 (
        .clk            (clk),
        .rst            (rst),
        .pixel_data_i   (pixel_data),
        .pixel_x_i      (pixel_x),
        .pixel_y_i      (pixel_y),
        .pixel_write_i  (pixel_write),
        .pal_data_i     (pal_data),
        .pal_index_i    (pal_index),
        .pal_write_i    (pal_write),
        .frame_start_i  (frame_start),
        .display_data_i (display_data),
        .pixel_valid_i  (pixel_valid),
        .hsync_i        (hsync),
        .vsync_i        (vsync),
        .frame_ready_i  (frame_ready),
        .busy_i         (busy),
        .errors_o       (chk_errors)
    );

    task automatic add_row(input int test, input int op, input int x, input int y,
                           input int idx, input logic [31:0] data, input bit drop);
        row_test[n_rows] = test;
        row_op[n_rows]   = op;
        row_x[n_rows]    = x;
        row_y[n_rows]    = y;
        row_idx[n_rows]  = idx;
        row_data[n_rows] = data;
        row_drop[n_rows] = drop;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] d;
        int          keep_idx;  // Index shown at pixel (3,2)
        int          old_idx;   // Index shown at pixel (0,0)
        for (int i = 0; i < gfx_pkg::PAL_WORDS; i++) begin
            d = $random(seed);
            add_row(1, OP_PAL, 0, 0, i, d, 1'b0);
        end
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                d = $random(seed);
                if (x == 3 && y == 2) begin
                    keep_idx = d[7:0];
                end
                if (x == 0 && y == 0) begin
                    old_idx = d[7:0];
                end
                add_row(1, OP_PIX, x, y, 0, d, 1'b0);
            end
        end
        add_row(1, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(1, OP_WAIT, 0, 0, 0, 0, 1'b0);
        add_row(2, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(2, OP_WAIT, 0, 0, 0, 0, 1'b0);
        // Writes issued mid-scan and a frame that must show the old colours
        add_row(3, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(3, OP_IDLE, 0, 0, 0, 0, 1'b0);
        d = $random(seed);
        add_row(3, OP_PIX, 2, 1, 0, d, 1'b1);
        d = $random(seed);
        add_row(3, OP_PAL, 0, 0, old_idx, d, 1'b1);
        add_row(3, OP_WAIT, 0, 0, 0, 0, 1'b0);
        add_row(3, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(3, OP_WAIT, 0, 0, 0, 0, 1'b0);
        d = $random(seed);
        add_row(4, OP_PIX, 37, 33, 0, d, 1'b0);  // Same word as (5,1)
        add_row(4, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(4, OP_WAIT, 0, 0, 0, 0, 1'b0);
        d = $random(seed);
        add_row(5, OP_PAL, 0, 0, keep_idx, d, 1'b0);
        add_row(5, OP_START, 0, 0, 0, 0, 1'b0);
        add_row(5, OP_WAIT, 0, 0, 0, 0, 1'b0);
        add_row(6, OP_START, 0, 0, 0, 0, 1'b0);
        for (int i = 0; i < 5; i++) begin
            add_row(6, OP_IDLE, 0, 0, 0, 0, 1'b0);
        end
        add_row(6, OP_START, 0, 0, 0, 0, 1'b1);
        add_row(6, OP_WAIT, 0, 0, 0, 0, 1'b0);
    endtask

    task automatic apply_row(input int r);
        @(posedge clk);
        pixel_write <= 1'b0;
        pal_write   <= 1'b0;
        frame_start <= 1'b0;
        case (row_op[r])
            OP_PIX: begin
                pixel_x     <= gfx_pkg::coord_t'(row_x[r]);
                pixel_y     <= gfx_pkg::coord_t'(row_y[r]);
                pixel_data  <= row_data[r];
                pixel_write <= 1'b1;
            end
            OP_PAL: begin
                pal_index <= gfx_pkg::pal_addr_t'(row_idx[r]);
                pal_data  <= row_data[r][23:0];
                pal_write <= 1'b1;
            end
            OP_START: frame_start <= 1'b1;
            default: ;
        endcase
        @(negedge clk);
        // busy_o here is what the next edge uses to accept or drop the strobe
        if (row_op[r] inside {OP_PIX, OP_PAL, OP_START} && busy !== row_drop[r]) begin
            tb_errors++;
            if (row_drop[r]) begin
                $display("row %0d: busy_o is low where the strobe should be dropped", r);
            end else begin
                $display("row %0d: busy_o is high where the strobe should be accepted", r);
            end
        end
        if (row_op[r] == OP_WAIT) begin
            while (frame_ready !== 1'b1) @(negedge clk);
            @(negedge clk);
        end
    endtask

    // Run limit from the table length and the number of frames
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int errors_before;
        int errs;
        int frames;
        pixel_data  = '0;
        pixel_x     = '0;
        pixel_y     = '0;
        pixel_write = 1'b0;
        pal_data    = '0;
        pal_index   = '0;
        pal_write   = 1'b0;
        frame_start = 1'b0;
        test_name[1] = "full scan";
        test_name[2] = "line and frame strobes";
        test_name[3] = "writes dropped in scan";
        test_name[4] = "tile wrap";
        test_name[5] = "palette update";
        test_name[6] = "frame_start in scan";
        build_table();
        frames = 0;
        for (int r = 0; r < n_rows; r++) begin
            if (row_op[r] == OP_START && !row_drop[r]) begin
                frames++;
            end
        end
        limit = n_rows + frames * 3 * (FRAME_W * FRAME_H + 4) + RESET_CYCLES + 100;

        wait (rst === 1'b0);
        errors_before = 0;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
            if (r == n_rows - 1 || row_test[r + 1] != row_test[r]) begin
                @(posedge clk);  // Checker is done with the last falling edge
                errs = chk_errors + tb_errors - errors_before;
                errors_before = chk_errors + tb_errors;
                if (errs == 0) begin
                    tests_passed++;
                    $display("test %0d %s: ok", row_test[r], test_name[row_test[r]]);
                end else begin
                    tests_failed++;
                    $display("test %0d %s: %0d errors", row_test[r], test_name[row_test[r]],
                             errs);
                end
            end
        end
        repeat (4) @(posedge clk);  // Let the checker see a few idle cycles

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: gfx_host.f
verilog/gfx_pkg.sv
verilog/sync_ram.sv
verilog/host_port.sv
verilog/scan_controller.sv
verilog/gfx_host.sv
tests/tb_clock.sv
tests/gfx_checker.sv
tests/gfx_host_tb.sv

// File: Bender.yml
package:
  name: gfx_host

sources:
  - verilog/gfx_pkg.sv
  - verilog/sync_ram.sv
  - verilog/host_port.sv
  - verilog/scan_controller.sv
  - verilog/gfx_host.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/gfx_checker.sv
      - tests/gfx_host_tb.sv
